// ==== design/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

   localparam int DATA_W = 32;

   typedef enum logic [2:0] {
      LB,
      LH,
      LW,
      LBU,
      LHU,
      SB,
      SH,
      SW
   } lsu_op_e;

   // access size of an opcode, packed as {word, half, signed}.
   function automatic logic [2:0] size_of(input lsu_op_e op);
      logic [2:0] flags;
      case (op)
         LB:      flags = 3'b001;
         LH:      flags = 3'b011;
         LW:      flags = 3'b100;
         LBU:     flags = 3'b000;
         LHU:     flags = 3'b010;
         SB:      flags = 3'b000;
         SH:      flags = 3'b010;
         SW:      flags = 3'b100;
         default: flags = 3'b000;
      endcase
      return flags;
   endfunction

   function automatic logic is_store(input lsu_op_e op);
      return op inside {SB, SH, SW};
   endfunction

endpackage

`default_nettype wire

// ==== design/lsu_sequencer.sv ====
`default_nettype none

module lsu_sequencer #(
   parameter int ADDR_W = 8
) (
   input  wire                       i_clk,
   input  wire                       i_arst_n,
   input  wire                       i_start,
   input  wire lsu_pkg::lsu_op_e     i_op,
   input  wire [ADDR_W-1:0]          i_addr,
   input  wire [lsu_pkg::DATA_W-1:0] i_wdata,
   input  wire                       i_misalign,
   output logic                      o_busy,
   output logic                      o_done,
   output logic                      o_load,
   output logic                      o_en,
   output logic                      o_init,
   output logic                      o_cmd,
   output logic                      o_word,
   output logic                      o_half,
   output logic                      o_signed,
   output logic [1:0]                o_bytecnt,
   output logic [1:0]                o_lsb,
   output logic                      o_rs2,
   output logic                      o_cyc,
   output logic [ADDR_W-3:0]         o_adr,
   output logic                      o_shift_out
);

   import lsu_pkg::*;

   typedef enum logic [2:0] {
      IDLE,
      INIT,
      BUS,
      WAIT_ACK,
      READ,
      DONE
   } state_e;

   state_e            state;
   logic [4:0]        cnt;
   logic [ADDR_W-1:0] addr_q;
   logic [DATA_W-1:0] wdat_q;

   // ==================================================
   // command phases
   // ==================================================

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         state    <= IDLE;
         cnt      <= '0;
         o_cyc    <= 1'b0;
         o_cmd    <= 1'b0;
         o_load   <= 1'b0;
         o_word   <= 1'b0;
         o_half   <= 1'b0;
         o_signed <= 1'b0;
      end else begin
         case (state)
            IDLE: begin
               if (i_start) begin
                  state                      <= INIT;
                  cnt                        <= '0;
                  {o_word, o_half, o_signed} <= size_of(i_op);
                  o_cmd                      <= is_store(i_op);
                  o_load                     <= !is_store(i_op);
               end
            end
            INIT: begin
               cnt <= cnt + 5'd1;
               if (cnt == 5'd31)
                  state <= BUS;
            end
            // the first cycle here checks alignment, the second carries the request.
            BUS: begin
               if (o_cyc) begin
                  o_cyc <= 1'b0;
                  state <= WAIT_ACK;
               end else if (i_misalign) begin
                  state <= DONE;
               end else begin
                  o_cyc <= 1'b1;
               end
            end
            // the RAM always answers one cycle after the request.
            WAIT_ACK: begin
               cnt   <= '0;
               state <= o_cmd ? DONE : READ;
            end
            READ: begin
               cnt <= cnt + 5'd1;
               if (cnt == 5'd31)
                  state <= DONE;
            end
            DONE: state <= IDLE;
            default: state <= IDLE;
         endcase
      end
   end

   // store word drops one bit per init cycle, lsb first.
   always_ff @(posedge i_clk) begin
      if (state == IDLE && i_start) begin
         addr_q <= i_addr;
         wdat_q <= i_wdata;
      end else if (state == INIT) begin
         wdat_q <= wdat_q >> 1;
      end
   end

   assign o_busy      = (state != IDLE);
   assign o_done      = (state == DONE);
   assign o_init      = (state == INIT);
   assign o_shift_out = (state == READ);
   assign o_en        = o_init | o_shift_out;
   assign o_bytecnt   = cnt[4:3];
   assign o_lsb       = addr_q[1:0];
   assign o_adr       = addr_q[ADDR_W-1:2];
   assign o_rs2       = wdat_q[0];

   // ==================================================
   // checks
   // ==================================================

   // a request only goes out in the bus phase of an aligned access.
   assert property (@(posedge i_clk) disable iff (!i_arst_n)
      o_cyc |-> state == BUS && !i_misalign);

   // a start seen while busy must not restart the init phase.
   assert property (@(posedge i_clk) disable iff (!i_arst_n)
      o_busy && i_start |=> !(state == INIT && cnt == 5'd0));

endmodule

`default_nettype wire

// ==== design/lsu_mem_if.sv ====
`default_nettype none

module lsu_mem_if (
   input  wire                        i_clk,
   input  wire                        i_arst_n,
   input  wire                        i_en,
   input  wire                        i_init,
   input  wire                        i_cmd,
   input  wire                        i_signed,
   input  wire                        i_word,
   input  wire                        i_half,
   input  wire  [1:0]                 i_bytecnt,
   input  wire                        i_rs2,
   input  wire  [1:0]                 i_lsb,
   input  wire  [lsu_pkg::DATA_W-1:0] i_wb_rdt,
   input  wire                        i_wb_ack,
   output logic                       o_rd,
   output logic                       o_misalign,
   output logic [lsu_pkg::DATA_W-1:0] o_wb_dat,
   output logic [3:0]                 o_wb_sel,
   output logic                       o_wb_we
);

   logic [7:0] lane [4];
   logic [3:0] lane_en;
   logic [3:0] wbyte;
   logic [1:0] bytepos;
   logic [1:0] dat_sel;
   logic       dat_cur;
   logic       dat_valid;
   logic       signbit;

   // ==================================================
   // lane selection
   // ==================================================

   // upper byte counts address lanes directly, lower ones are offset by the position.
   assign dat_sel   = i_bytecnt[1] ? i_bytecnt : (i_bytecnt | bytepos);
   assign dat_cur   = lane[dat_sel][0];
   assign dat_valid = i_word | (i_bytecnt == 2'd0) | (i_half & !i_bytecnt[1]);
   assign o_rd      = dat_valid ? dat_cur : (signbit & i_signed);

   // during init the low byte lands in every lane and the low half in both halves.
   always_comb begin
      wbyte[0] = (i_bytecnt == 2'd0);
      wbyte[1] = (i_bytecnt == 2'd1) & !bytepos[0];
      wbyte[2] = (i_bytecnt == 2'd2) & !bytepos[1];
      wbyte[3] = (i_bytecnt == 2'd3) & !bytepos[1];
   end

   assign lane_en[0] = i_en & (i_init ? wbyte[0] : (dat_sel == 2'd0));
   assign lane_en[1] = i_en & (i_init ? (wbyte[0] | wbyte[1]) : (dat_sel == 2'd1));
   assign lane_en[2] = i_en & (i_init ? (wbyte[0] | wbyte[2]) : (dat_sel == 2'd2));
   assign lane_en[3] = i_en & (i_init ? (wbyte[0] | wbyte[1] | wbyte[3])
                                      : (dat_sel == 2'd3));

   always_comb begin
      if (i_word)
         o_wb_sel = 4'b1111;
      else if (i_half)
         o_wb_sel = bytepos[1] ? 4'b1100 : 4'b0011;
      else
         o_wb_sel = 4'b0001 << bytepos;
   end

   assign o_wb_dat = {lane[3], lane[2], lane[1], lane[0]};
   assign o_wb_we  = i_cmd;

   // ==================================================
   // storage
   // ==================================================

   always_ff @(posedge i_clk) begin
      if (i_wb_ack) begin
         for (int i = 0; i < 4; i++)
            lane[i] <= i_wb_rdt[8*i +: 8];
      end else begin
         for (int i = 0; i < 4; i++) begin
            if (lane_en[i])
               lane[i] <= {i_rs2, lane[i][7:1]};
         end
      end
      // last valid bit out is the sign of the loaded value.
      if (i_en & dat_valid)
         signbit <= dat_cur;
   end

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         bytepos    <= 2'd0;
         o_misalign <= 1'b0;
      end else begin
         if (i_init)
            bytepos <= i_lsb;
         o_misalign <= (bytepos[0] & (i_word | i_half)) | (bytepos[1] & i_word);
      end
   end

   // an acknowledged write implies the sequencer saw an aligned access.
   assert property (@(posedge i_clk) disable iff (!i_arst_n)
      i_wb_ack && o_wb_we |-> !o_misalign);

endmodule

`default_nettype wire

// ==== design/lsu_data_ram.sv ====
`default_nettype none

module lsu_data_ram #(
   parameter int ADDR_W = 8
) (
   input  wire                          i_clk,
   input  wire                          i_arst_n,
   input  wire                          i_cyc,
   input  wire  [ADDR_W-3:0]            i_adr,
   input  wire                          i_we,
   input  wire  [lsu_pkg::DATA_W/8-1:0] i_sel,
   input  wire  [lsu_pkg::DATA_W-1:0]   i_dat,
   output logic [lsu_pkg::DATA_W-1:0]   o_rdt,
   output logic                         o_ack
);

   import lsu_pkg::*;

   localparam int DEPTH = 2 ** (ADDR_W - 2);

   logic [DATA_W-1:0] mem [DEPTH];

   // one access per request, writes merge the selected bytes only.
   always_ff @(posedge i_clk) begin
      if (i_cyc) begin
         if (i_we) begin
            for (int b = 0; b < DATA_W / 8; b++) begin
               if (i_sel[b])
                  mem[i_adr][8*b +: 8] <= i_dat[8*b +: 8];
            end
         end else begin
            o_rdt <= mem[i_adr];
         end
      end
   end

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n)
         o_ack <= 1'b0;
      else
         o_ack <= i_cyc;
   end

   assert property (@(posedge i_clk) disable iff (!i_arst_n)
      o_ack |=> !o_ack);

endmodule

`default_nettype wire

// ==== design/lsu_load_collect.sv ====
`default_nettype none

module lsu_load_collect (
   input  wire                        i_clk,
   input  wire                        i_arst_n,
   input  wire                        i_shift,
   input  wire                        i_bit,
   input  wire                        i_done,
   input  wire                        i_load,
   output logic [lsu_pkg::DATA_W-1:0] o_rdata
);

   import lsu_pkg::*;

   logic [$clog2(DATA_W):0] nshift;

   // ==================================================
   // result register
   // ==================================================

   // bits arrive lsb first, so each one enters at the top.
   always_ff @(posedge i_clk) begin
      if (i_shift)
         o_rdata <= {i_bit, o_rdata[DATA_W-1:1]};
   end

   // count of bits gathered for the command in flight.
   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n)
         nshift <= '0;
      else if (i_done)
         nshift <= '0;
      else if (i_shift)
         nshift <= nshift + 1'b1;
   end

   // shifting only happens for loads, and then for a full word.
   assert property (@(posedge i_clk) disable iff (!i_arst_n)
      i_done && (nshift != '0) |-> i_load && (nshift == DATA_W));

endmodule

`default_nettype wire

// ==== design/lsu_top.sv ====
`default_nettype none

module lsu_top #(
   parameter int ADDR_W = 8
) (
   input  wire                        i_clk,
   input  wire                        i_arst_n,
   input  wire                        i_start,
   input  wire lsu_pkg::lsu_op_e      i_op,
   input  wire  [ADDR_W-1:0]          i_addr,
   input  wire  [lsu_pkg::DATA_W-1:0] i_wdata,
   output logic                       o_busy,
   output logic                       o_done,
   output logic                       o_misalign,
   output logic [lsu_pkg::DATA_W-1:0] o_rdata,
   output logic                       o_load
);

   import lsu_pkg::*;

   logic              en;
   logic              init;
   logic              cmd;
   logic              word;
   logic              half;
   logic              sgn;
   logic [1:0]        bytecnt;
   logic [1:0]        lsb;
   logic              rs2;
   logic              cyc;
   logic [ADDR_W-3:0] adr;
   logic              shift_out;
   logic              rd;
   logic [DATA_W-1:0] wb_dat;
   logic [3:0]        wb_sel;
   logic              wb_we;
   logic [DATA_W-1:0] wb_rdt;
   logic              wb_ack;

   lsu_sequencer #(.ADDR_W(ADDR_W)) seq_i (
      .i_clk       (i_clk),
      .i_arst_n    (i_arst_n),
      .i_start     (i_start),
      .i_op        (i_op),
      .i_addr      (i_addr),
      .i_wdata     (i_wdata),
      .i_misalign  (o_misalign),
      .o_busy      (o_busy),
      .o_done      (o_done),
      .o_load      (o_load),
      .o_en        (en),
      .o_init      (init),
      .o_cmd       (cmd),
      .o_word      (word),
      .o_half      (half),
      .o_signed    (sgn),
      .o_bytecnt   (bytecnt),
      .o_lsb       (lsb),
      .o_rs2       (rs2),
      .o_cyc       (cyc),
      .o_adr       (adr),
      .o_shift_out (shift_out)
   );

   lsu_mem_if mem_if_i (
      .i_clk      (i_clk),
      .i_arst_n   (i_arst_n),
      .i_en       (en),
      .i_init     (init),
      .i_cmd      (cmd),
      .i_signed   (sgn),
      .i_word     (word),
      .i_half     (half),
      .i_bytecnt  (bytecnt),
      .i_rs2      (rs2),
      .i_lsb      (lsb),
      .i_wb_rdt   (wb_rdt),
      .i_wb_ack   (wb_ack),
      .o_rd       (rd),
      .o_misalign (o_misalign),
      .o_wb_dat   (wb_dat),
      .o_wb_sel   (wb_sel),
      .o_wb_we    (wb_we)
   );

   lsu_data_ram #(.ADDR_W(ADDR_W)) ram_i (
      .i_clk    (i_clk),
      .i_arst_n (i_arst_n),
      .i_cyc    (cyc),
      .i_adr    (adr),
      .i_we     (wb_we),
      .i_sel    (wb_sel),
      .i_dat    (wb_dat),
      .o_rdt    (wb_rdt),
      .o_ack    (wb_ack)
   );

   lsu_load_collect collect_i (
      .i_clk    (i_clk),
      .i_arst_n (i_arst_n),
      .i_shift  (shift_out),
      .i_bit    (rd),
      .i_done   (o_done),
      .i_load   (o_load),
      .o_rdata  (o_rdata)
   );

endmodule

`default_nettype wire

// ==== bench/lsu_tb.sv ====
`default_nettype none

module lsu_tb;

   import lsu_pkg::*;

   localparam int ADDR_W   = 8;
   localparam int N_CMDS   = 300;
   localparam int MAX_WAIT = 100;
   localparam int WATCHDOG = (N_CMDS * 80 + 500) * 10;

   logic              i_clk;
   logic              i_arst_n;
   logic              i_start;
   lsu_op_e           i_op;
   logic [ADDR_W-1:0] i_addr;
   logic [31:0]       i_wdata;
   logic              o_busy;
   logic              o_done;
   logic              o_misalign;
   logic [31:0]       o_rdata;
   logic              o_load;

   logic [7:0]  model_mem [2**ADDR_W];
   logic [31:0] lfsr;
   logic [31:0] exp_rdata;
   logic        exp_mis;
   logic        exp_load;
   int          errors;
   int          ncmds;
   int          ntests;
   int          test_errors;
   int          test_cmds;

   lsu_top #(.ADDR_W(ADDR_W)) dut_i (
      .i_clk      (i_clk),
      .i_arst_n   (i_arst_n),
      .i_start    (i_start),
      .i_op       (i_op),
      .i_addr     (i_addr),
      .i_wdata    (i_wdata),
      .o_busy     (o_busy),
      .o_done     (o_done),
      .o_misalign (o_misalign),
      .o_rdata    (o_rdata),
      .o_load     (o_load)
   );

   initial i_clk = 1'b0;
   always #5 i_clk = ~i_clk;

   // ==================================================
   // checks on the done cycle
   // ==================================================

   assert property (@(posedge i_clk) disable iff (!i_arst_n)
      o_done && exp_load && !exp_mis |-> o_rdata == exp_rdata)
   else begin
      errors++;
      $display("[FAIL] o_rdata: got 0x%08h expected 0x%08h",
               $sampled(o_rdata), $sampled(exp_rdata));
   end

   assert property (@(posedge i_clk) disable iff (!i_arst_n)
      o_done |-> o_misalign == exp_mis)
   else begin
      errors++;
      $display("[FAIL] o_misalign: got 0x%0h expected 0x%0h",
               $sampled(o_misalign), $sampled(exp_mis));
   end

   assert property (@(posedge i_clk) disable iff (!i_arst_n)
      o_done |-> o_load == exp_load)
   else begin
      errors++;
      $display("[FAIL] o_load: got 0x%0h expected 0x%0h", $sampled(o_load), $sampled(exp_load));
   end

   assert property (@(posedge i_clk) disable iff (!i_arst_n)
      o_done |=> !o_done && !o_busy)
   else begin
      errors++;
      $display("done lasted more than one cycle or the unit stayed busy after it");
   end

   // busy rises on an accepted start and stays up until done.
   assert property (@(posedge i_clk) disable iff (!i_arst_n)
      (i_start || o_busy) && !o_done |=> o_busy)
   else begin
      errors++;
      $display("[FAIL] o_busy: got 0x0 expected 0x1");
   end

   // ==================================================
   // stimulus and reference model
   // ==================================================

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return (s >> 1) ^ (s[0] ? 32'h80200003 : 32'h0);
   endfunction

   task automatic draw_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         v = {v[30:0], lfsr[0]};
      end
   endtask

   // byte-addressed shadow of the data RAM.
   task automatic model_cmd(input lsu_op_e op, input logic [ADDR_W-1:0] a,
                            input logic [31:0] wd, output logic [31:0] rd,
                            output logic mis, output logic ld, output int len);
      int          nbytes;
      logic        sext;
      logic [31:0] v;
      nbytes = (op == LW || op == SW) ? 4 : ((op == LH || op == LHU || op == SH) ? 2 : 1);
      sext   = (op == LB || op == LH);
      ld     = !(op == SB || op == SH || op == SW);
      mis    = (nbytes == 2 && a[0]) || (nbytes == 4 && a[1:0] != 2'd0);
      v      = '0;
      if (mis) begin
         len = 34;
      end else if (!ld) begin
         for (int i = 0; i < nbytes; i++)
            model_mem[a + i] = wd[8*i +: 8];
         len = 36;
      end else begin
         for (int i = 0; i < nbytes; i++)
            v[8*i +: 8] = model_mem[a + i];
         for (int i = 8 * nbytes; i < 32; i++)
            v[i] = sext & v[8*nbytes-1];
         len = 68;
      end
      rd = v;
   endtask

   task automatic run_cmd(input lsu_op_e op, input logic [ADDR_W-1:0] a,
                          input logic [31:0] wd, input logic poke);
      logic [31:0] rd;
      logic        mis;
      logic        ld;
      int          len;
      int          n;
      while (o_busy)
         @(negedge i_clk);
      model_cmd(op, a, wd, rd, mis, ld, len);
      exp_rdata = rd;
      exp_mis   = mis;
      exp_load  = ld;
      i_op      = op;
      i_addr    = a;
      i_wdata   = wd;
      i_start   = 1'b1;
      n         = 0;
      // latency counts rising edges from the one that takes the start.
      do begin
         @(negedge i_clk);
         n++;
         i_start = poke && (n == 10);
         if (i_start) begin
            i_op    = SW;
            i_addr  = ~a;
            i_wdata = ~wd;
         end
      end while (!o_done && n < MAX_WAIT);
      ncmds++;
      if (!o_done) begin
         $display("command %0d got no done within %0d cycles of its start", ncmds, MAX_WAIT);
         $display("=== FAIL ===");
         $finish;
      end else begin
         assert (n == len)
         else begin
            errors++;
            $display("[FAIL] done latency: got 0x%0h expected 0x%0h", n, len);
         end
         // the done-cycle properties sample on the next rising edge.
         @(negedge i_clk);
      end
   endtask

   task automatic start_test();
      test_errors = errors;
      test_cmds   = ncmds;
   endtask

   task automatic report_test(input int num, input string name);
      ntests++;
      $display("test %0d %s: %0d commands, %0d errors", num, name,
               ncmds - test_cmds, errors - test_errors);
   endtask

   initial begin
      logic [31:0]       r;
      logic [31:0]       d;
      logic [7:0]        w;
      logic [ADDR_W-1:0] a;
      lsu_op_e           op;
      i_arst_n = 1'b0;
      i_start  = 1'b0;
      i_op     = LB;
      i_addr   = '0;
      i_wdata  = '0;
      lfsr     = 32'hee0167c1;
      errors   = 0;
      ncmds    = 0;
      ntests   = 0;
      repeat (4) @(negedge i_clk);
      i_arst_n = 1'b1;

      start_test();
      assert (!o_busy && !o_done)
      else begin
         errors++;
         $display("[FAIL] o_busy/o_done after reset: got 0x%0h expected 0x0", {o_busy, o_done});
      end
      // every word gets a value built from its own address.
      for (int k = 0; k < 2**(ADDR_W-2); k++) begin
         w = 8'(k);
         run_cmd(SW, ADDR_W'(4 * k), {w ^ 8'h3c, ~w, w + 8'h71, w}, 1'b0);
      end
      run_cmd(SW, 8'h10, 32'h1234abcd, 1'b0);
      run_cmd(LW, 8'h10, 32'h0, 1'b0);
      run_cmd(SH, 8'h22, 32'hdead0765, 1'b0);
      run_cmd(LHU, 8'h22, 32'h0, 1'b0);
      run_cmd(SB, 8'h33, 32'hffffff5c, 1'b0);
      run_cmd(LBU, 8'h33, 32'h0, 1'b0);
      run_cmd(LW, 8'h20, 32'h0, 1'b0);
      run_cmd(LW, 8'h30, 32'h0, 1'b0);
      report_test(1, "aligned stores and loads");

      start_test();
      run_cmd(SW, 8'h40, 32'hf08192a3, 1'b0);
      for (int k = 0; k < 4; k++) begin
         run_cmd(LB, 8'h40 + 8'(k), 32'h0, 1'b0);
         run_cmd(LBU, 8'h40 + 8'(k), 32'h0, 1'b0);
      end
      run_cmd(LH, 8'h42, 32'h0, 1'b0);
      run_cmd(LHU, 8'h42, 32'h0, 1'b0);
      report_test(2, "sign and zero extension");

      start_test();
      for (int k = 0; k < 4; k++) begin
         run_cmd(SB, 8'h50 + 8'(k), {24'h5a5a5a, 8'hc0 + 8'(k)}, 1'b0);
         run_cmd(LW, 8'h50, 32'h0, 1'b0);
      end
      report_test(3, "byte lanes");

      start_test();
      run_cmd(SH, 8'h61, 32'h11112222, 1'b0);
      run_cmd(SW, 8'h62, 32'h33334444, 1'b0);
      run_cmd(SW, 8'h67, 32'h55556666, 1'b0);
      run_cmd(LH, 8'h63, 32'h0, 1'b0);
      run_cmd(LW, 8'h61, 32'h0, 1'b0);
      run_cmd(LW, 8'h60, 32'h0, 1'b0);
      run_cmd(LW, 8'h64, 32'h0, 1'b0);
      report_test(4, "misaligned access");

      start_test();
      for (int k = 0; k < 200; k++) begin
         draw_bits(3, r);
         op = lsu_op_e'(r[2:0]);
         draw_bits(ADDR_W, r);
         a = r[ADDR_W-1:0];
         draw_bits(1, r);
         if (r[0] && (op == LW || op == SW))
            a[1:0] = 2'd0;
         else if (r[0] && (op == LH || op == LHU || op == SH))
            a[0] = 1'b0;
         draw_bits(32, d);
         draw_bits(1, r);
         run_cmd(op, a, d, r[0]);
      end
      report_test(5, "random mix");

      $display("summary: %0d tests, %0d commands, %0d errors", ntests, ncmds, errors);
      if (errors == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG);
      $display("watchdog expired after %0d time units with tests still running", WATCHDOG);
      $display("=== FAIL ===");
      $finish;
   end

endmodule

`default_nettype wire

// ==== project.f ====
design/lsu_pkg.sv
design/lsu_sequencer.sv
design/lsu_mem_if.sv
design/lsu_data_ram.sv
design/lsu_load_collect.sv
design/lsu_top.sv
bench/lsu_tb.sv
